//--- sources.f
+incdir+tests
logic/cart_pkg.sv
logic/mem_pkg.sv
logic/load_bus_if.sv
logic/rom_header_detect.sv
logic/cheat_code_loader.sv
logic/ram_clear.sv
logic/cart_loader_top.sv
tests/tb_cart_loader.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_cart_loader -o sim_tb

# The simulator exits nonzero on failure, so keep its output for the search below
out=$(./obj_dir/sim_tb || true)
echo "$out"
echo "$out" | grep -q "^TEST OK$"

//--- tests/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// ==============================
// Header decode
// ==============================

// Low 10 + size bits set up to the full mask width
function automatic logic [23:0] size_mask(logic [3:0] size);
	logic [23:0] m;
	m = '0;
	for (int i = 0; i < 24; i++) begin
		if (i < 10 + int'(size)) begin
			m[i] = 1'b1;
		end
	end
	return m;
endfunction

function automatic logic [23:0] ram_size_mask(logic [3:0] size);
	return (size == 4'd0) ? 24'd0 : size_mask(size);
endfunction

// Packed as {ram size, rom size}
function automatic logic [7:0] auto_sizes(logic [7:0] lo);
	return (lo == 8'h00) ? {4'd0, 4'd12} : lo;
endfunction

function automatic logic [7:0] mode_rom_type(cart_pkg::header_mode_e mode, logic [7:0] hi);
	case (mode)
		cart_pkg::HDR_HIROM:   return 8'd1;
		cart_pkg::HDR_EXHIROM: return 8'd2;
		cart_pkg::HDR_AUTO:    return hi;
		default:               return 8'd0;
	endcase
endfunction

// Size byte offset including the copier header
function automatic logic [24:0] size_byte_offset(cart_pkg::header_mode_e mode);
	case (mode)
		cart_pkg::HDR_LOROM:   return 25'h0081D6;
		cart_pkg::HDR_HIROM:   return 25'h0101D6;
		cart_pkg::HDR_EXHIROM: return 25'h4101D6;
		default:               return 25'h0;
	endcase
endfunction

function automatic logic pal_for_region(cart_pkg::region_sel_e sel, logic region_bit);
	if (sel == cart_pkg::REG_AUTO) begin
		return region_bit;
	end
	return sel == cart_pkg::REG_PAL;
endfunction

// ==============================
// Fill bytes and codes
// ==============================

function automatic logic [7:0] fill_for_addr(mem_pkg::fill_pattern_e pat, logic [16:0] addr);
	logic [7:0] b;
	case (pat)
		mem_pkg::FILL_9966: b = (addr[8] != addr[2]) ? 8'h66 : 8'h99;
		mem_pkg::FILL_00FF: b = (addr[9] != addr[0]) ? 8'hFF : 8'h00;
		mem_pkg::FILL_55:   b = 8'h55;
		default:            b = 8'hFF;
	endcase
	return b;
endfunction

// Word i of the code sits at bits 16*i and was sent at offset 2*i
function automatic cart_pkg::cheat_code_t assemble_code(logic [127:0] words);
	cart_pkg::cheat_code_t c;
	c.flags   = {words[31:16], words[15:0]};
	c.address = {words[63:48], words[47:32]};
	c.compare = {words[95:80], words[79:64]};
	c.replace = {words[127:112], words[111:96]};
	return c;
endfunction

`endif

//--- tests/tb_cart_loader.sv
`timescale 1ns/1ps

module tb_cart_loader;

	logic                                 clk_sys;
	logic                                 RESET;
	logic                                 load_active;
	logic [cart_pkg::LOAD_IDX_W-1:0]      load_index;
	logic [cart_pkg::LOAD_ADDR_W-1:0]     load_addr;
	logic [cart_pkg::LOAD_DATA_W-1:0]     load_data;
	logic                                 load_wr;
	cart_pkg::header_mode_e               header_mode;
	cart_pkg::region_sel_e                region_sel;
	mem_pkg::fill_pattern_e               wram_pattern;
	mem_pkg::fill_pattern_e               aram_pattern;
	logic [cart_pkg::ROM_TYPE_W-1:0]      rom_type;
	logic [cart_pkg::MASK_W-1:0]          rom_mask;
	logic [cart_pkg::MASK_W-1:0]          ram_mask;
	logic                                 pal;
	cart_pkg::cheat_code_t                code;
	logic                                 code_valid;
	logic                                 code_clear;
	logic                                 clear_active;
	logic [mem_pkg::CLEAR_ADDR_W-1:0]     clear_addr;
	logic [7:0]                           wram_fill;
	logic [7:0]                           aram_fill;

	integer                 seed;
	int                     failures;
	int                     codes_seen;
	int                     sweep_count;
	logic                   valid_prev;
	logic                   sweep_on;
	cart_pkg::cheat_code_t  exp_codes[$];

	`include "tb_ref.svh"

	cart_loader_top dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#2 clk_sys = ~clk_sys;
		end
	end

	// ==============================
	// Compare tasks
	// ==============================

	task automatic report_failure(input string what);
		failures++;
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			report_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_mask(input string name, input logic [cart_pkg::MASK_W-1:0] exp,
			input logic [cart_pkg::MASK_W-1:0] act);
		if (act !== exp) begin
			report_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_addr(input string name, input logic [mem_pkg::CLEAR_ADDR_W-1:0] exp,
			input logic [mem_pkg::CLEAR_ADDR_W-1:0] act);
		if (act !== exp) begin
			report_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_code(input string name, input cart_pkg::cheat_code_t exp,
			input cart_pkg::cheat_code_t act);
		if (act !== exp) begin
			report_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			report_failure($sformatf("Error: %s expected %b actual %b", name, exp, act));
		end
	endtask

	// ==============================
	// Stimulus tasks
	// ==============================

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic write_word(input logic [7:0] idx, input logic [24:0] addr,
			input logic [15:0] data);
		tick();
		load_active = 1'b1;
		load_index  = idx;
		load_addr   = addr;
		load_data   = data;
		load_wr     = 1'b1;
		tick();
		load_wr     = 1'b0;
	endtask

	task automatic end_download();
		tick();
		load_active = 1'b0;
		load_index  = 8'h00;
	endtask

	// Masks trail the last header write by two cycles
	task automatic check_header(input string name, input logic [7:0] exp_type,
			input logic [3:0] rom_sz, input logic [3:0] ram_sz);
		tick();
		@(negedge clk_sys);
		check_byte({name, " rom_type"}, exp_type, rom_type);
		check_mask({name, " rom_mask"}, size_mask(rom_sz), rom_mask);
		check_mask({name, " ram_mask"}, ram_size_mask(ram_sz), ram_mask);
	endtask

	// Comparing process for code strobes and the clear sweep
	always @(negedge clk_sys) begin
		if (!RESET) begin
			if (code_valid) begin
				if (valid_prev) begin
					report_failure("code_valid stayed high for two cycles");
				end
				if (exp_codes.size() == 0) begin
					report_failure("code_valid strobed with no code sent");
				end
				check_code("cheat code", exp_codes.pop_front(), code);
				codes_seen++;
			end
			valid_prev = code_valid;
			if (sweep_on && clear_active) begin
				check_addr("clear_addr", 17'(sweep_count), clear_addr);
				check_byte("wram_fill", fill_for_addr(wram_pattern, 17'(sweep_count)),
					wram_fill);
				check_byte("aram_fill", fill_for_addr(aram_pattern, 17'(sweep_count)),
					aram_fill);
				sweep_count++;
			end
		end
	end

	initial begin
		cart_pkg::header_mode_e modes[3];
		logic [15:0]  word;
		logic [15:0]  rom_word;
		logic [15:0]  ram_word;
		logic [7:0]   sizes;
		logic [24:0]  ofs;
		logic [127:0] words;
		int           t;

		seed         = 32'h5990051c;
		failures     = 0;
		codes_seen   = 0;
		sweep_count  = 0;
		valid_prev   = 1'b0;
		sweep_on     = 1'b0;
		RESET        = 1'b1;
		load_active  = 1'b0;
		load_index   = 8'h00;
		load_addr    = '0;
		load_data    = '0;
		load_wr      = 1'b0;
		header_mode  = cart_pkg::HDR_AUTO;
		region_sel   = cart_pkg::REG_AUTO;
		wram_pattern = mem_pkg::FILL_9966;
		aram_pattern = mem_pkg::FILL_9966;
		modes[0]     = cart_pkg::HDR_LOROM;
		modes[1]     = cart_pkg::HDR_HIROM;
		modes[2]     = cart_pkg::HDR_EXHIROM;

		repeat (2) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		@(negedge clk_sys);
		check_bit("reset code_valid", 1'b0, code_valid);
		check_bit("reset code_clear", 1'b0, code_clear);
		check_bit("reset clear_active", 1'b0, clear_active);
		check_addr("reset clear_addr", 17'd0, clear_addr);
		check_bit("reset pal", 1'b0, pal);

		// Auto header with a nonzero then a zero size byte
		word = 16'($random(seed));
		if (word[7:0] == 8'h00) begin
			word[0] = 1'b1;
		end
		for (int pass = 0; pass < 2; pass++) begin
			write_word(8'h00, 25'd0, word);
			sizes = auto_sizes(word[7:0]);
			check_header("auto header", mode_rom_type(cart_pkg::HDR_AUTO, word[15:8]),
				sizes[3:0], sizes[7:4]);
			check_bit("code_clear in cart download", 1'b1, code_clear);
			word[7:0] = 8'h00;
		end

		// Forced layouts
		for (int m = 0; m < 3; m++) begin
			tick();
			header_mode = modes[m];
			ofs         = size_byte_offset(modes[m]);
			rom_word    = 16'($random(seed));
			ram_word    = 16'($random(seed));
			write_word(8'h00, 25'd0, 16'($random(seed)));
			write_word(8'h00, ofs, rom_word);
			write_word(8'h00, ofs + 25'd2, ram_word);
			check_header(modes[m].name(), mode_rom_type(modes[m], 8'h00),
				rom_word[11:8], ram_word[3:0]);
		end

		// Region bit then a step through the selections
		tick();
		header_mode = cart_pkg::HDR_AUTO;
		word = 16'($random(seed)) | 16'h0100;
		write_word(8'h00, 25'd2, word);
		end_download();
		for (int s = 0; s < 3; s++) begin
			tick();
			region_sel = cart_pkg::region_sel_e'(2'(s));
			tick();
			@(negedge clk_sys);
			check_bit({"pal ", region_sel.name()}, pal_for_region(region_sel, word[8]), pal);
		end

		// Three cheat codes of eight words
		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < 8; i++) begin
				words[16*i +: 16] = 16'($random(seed));
			end
			exp_codes.push_back(assemble_code(words));
			for (int i = 0; i < 8; i++) begin
				write_word(8'hFF, 25'(16 * k + 2 * i), words[16*i +: 16]);
				if (k == 0 && i == 0) begin
					@(negedge clk_sys);
					check_bit("code_clear pulse", 1'b1, code_clear);
					@(negedge clk_sys);
					check_bit("code_clear end", 1'b0, code_clear);
				end
			end
		end
		for (t = 0; t < 20 && codes_seen < 3; t++) begin
			tick();
		end
		if (codes_seen != 3) begin
			report_failure("timed out waiting for the cheat code strobes");
		end
		end_download();

		// Sweep from the earlier cartridge download has to finish first
		for (t = 0; t < 140000 && clear_active; t++) begin
			tick();
		end
		if (clear_active) begin
			report_failure("earlier RAM clear sweep never finished");
		end
		wram_pattern = mem_pkg::fill_pattern_e'(2'($random(seed)));
		aram_pattern = mem_pkg::fill_pattern_e'(2'($random(seed)));
		sweep_count  = 0;
		sweep_on     = 1'b1;
		load_active  = 1'b1;
		load_index   = 8'h00;
		for (t = 0; t < 10 && !clear_active; t++) begin
			tick();
		end
		if (!clear_active) begin
			report_failure("clear_active never rose after the download started");
		end
		for (t = 0; t < 140000 && clear_active; t++) begin
			tick();
		end
		if (clear_active) begin
			report_failure("RAM clear sweep did not end");
		end
		sweep_on = 1'b0;
		if (sweep_count != 131072) begin
			report_failure($sformatf("RAM clear sweep ran %0d cycles instead of 131072",
				sweep_count));
		end
		end_download();

		if (failures == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			report_failure("checks failed during the run");
		end
	end

endmodule

//--- logic/cart_loader_top.sv
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                             clk_sys,
	input  logic                             RESET,

	// Download stream
	input  logic                             load_active,
	input  logic [cart_pkg::LOAD_IDX_W-1:0]  load_index,
	input  logic [cart_pkg::LOAD_ADDR_W-1:0] load_addr,
	input  logic [cart_pkg::LOAD_DATA_W-1:0] load_data,
	input  logic                             load_wr,

	// Options
	input  cart_pkg::header_mode_e           header_mode,
	input  cart_pkg::region_sel_e            region_sel,
	input  mem_pkg::fill_pattern_e           wram_pattern,
	input  mem_pkg::fill_pattern_e           aram_pattern,

	// Cartridge info
	output logic [cart_pkg::ROM_TYPE_W-1:0]  rom_type,
	output logic [cart_pkg::MASK_W-1:0]      rom_mask,
	output logic [cart_pkg::MASK_W-1:0]      ram_mask,
	output logic                             pal,

	// Cheat codes
	output cart_pkg::cheat_code_t            code,
	output logic                             code_valid,
	output logic                             code_clear,

	// RAM clear sweep
	output logic                             clear_active,
	output logic [mem_pkg::CLEAR_ADDR_W-1:0] clear_addr,
	output logic [7:0]                       wram_fill,
	output logic [7:0]                       aram_fill
);

	load_bus_if bus0 ();

	assign bus0.active = load_active;
	assign bus0.index  = load_index;
	assign bus0.addr   = load_addr;
	assign bus0.data   = load_data;
	assign bus0.wr     = load_wr;

	rom_header_detect hdr0 (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.bus         (bus0.sink),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	cheat_code_loader codes0 (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.bus        (bus0.sink),
		.code       (code),
		.code_valid (code_valid),
		.code_clear (code_clear)
	);

	ram_clear clr0 (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.bus          (bus0.sink),
		.wram_pattern (wram_pattern),
		.aram_pattern (aram_pattern),
		.clear_active (clear_active),
		.clear_addr   (clear_addr),
		.wram_fill    (wram_fill),
		.aram_fill    (aram_fill)
	);

endmodule

//--- logic/ram_clear.sv
`timescale 1ns/1ps

module ram_clear (
	input  logic                              clk_sys,
	input  logic                              RESET,
	load_bus_if.sink                          bus,
	input  mem_pkg::fill_pattern_e            wram_pattern,
	input  mem_pkg::fill_pattern_e            aram_pattern,
	output logic                              clear_active,
	output logic [mem_pkg::CLEAR_ADDR_W-1:0]  clear_addr,
	output logic [7:0]                        wram_fill,
	output logic [7:0]                        aram_fill
);

	logic cart_dl;
	logic cart_dl_d;
	logic start;

	assign cart_dl = bus.active && (bus.index[5:0] == cart_pkg::LOAD_IDX_CART);
	assign start   = cart_dl && !cart_dl_d;

	// ==============================
	// Sweep counter
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_d    <= 1'b0;
			clear_active <= 1'b0;
			clear_addr   <= '0;
		end else begin
			cart_dl_d <= cart_dl;
			if (start) begin
				clear_active <= 1'b1;
			end else if (clear_active && (&clear_addr)) begin
				// Top address was the last one written
				clear_active <= 1'b0;
			end
			if (clear_active) begin
				clear_addr <= clear_addr + mem_pkg::CLEAR_ADDR_STEP;
			end else begin
				clear_addr <= '0;
			end
		end
	end

	// Fill data lines up with the address
	assign wram_fill = mem_pkg::fill_byte(wram_pattern, clear_addr);
	assign aram_fill = mem_pkg::fill_byte(aram_pattern, clear_addr);

	a_idle_addr: assert property (@(posedge clk_sys) disable iff (RESET)
		!clear_active |-> clear_addr == '0);

endmodule

//--- logic/cheat_code_loader.sv
`timescale 1ns/1ps

module cheat_code_loader (
	input  logic                  clk_sys,
	input  logic                  RESET,
	load_bus_if.sink              bus,
	output cart_pkg::cheat_code_t code,
	output logic                  code_valid,
	output logic                  code_clear
);

	logic cart_dl;
	logic take;
	logic clr_pulse;

	assign cart_dl = bus.active && (bus.index[5:0] == cart_pkg::LOAD_IDX_CART);
	assign take    = bus.active && bus.wr && (bus.index == cart_pkg::LOAD_IDX_CODE);

	// Eight words per code with the low half first
	always_ff @(posedge clk_sys) begin
		if (take) begin
			case (bus.addr[3:0])
				4'd0:  code.flags[15:0]    <= bus.data;
				4'd2:  code.flags[31:16]   <= bus.data;
				4'd4:  code.address[15:0]  <= bus.data;
				4'd6:  code.address[31:16] <= bus.data;
				4'd8:  code.compare[15:0]  <= bus.data;
				4'd10: code.compare[31:16] <= bus.data;
				4'd12: code.replace[15:0]  <= bus.data;
				4'd14: code.replace[31:16] <= bus.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
			clr_pulse  <= 1'b0;
		end else begin
			// Last word completes the code
			code_valid <= take && (bus.addr[3:0] == 4'd14);
			// New code list starts at address 0
			clr_pulse  <= take && (bus.addr == '0);
		end
	end

	assign code_clear = cart_dl || clr_pulse;

	a_valid_single: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid);

endmodule

//--- logic/rom_header_detect.sv
`timescale 1ns/1ps

module rom_header_detect (
	input  logic                            clk_sys,
	input  logic                            RESET,
	load_bus_if.sink                        bus,
	input  cart_pkg::header_mode_e          header_mode,
	input  cart_pkg::region_sel_e           region_sel,
	output logic [cart_pkg::ROM_TYPE_W-1:0] rom_type,
	output logic [cart_pkg::MASK_W-1:0]     rom_mask,
	output logic [cart_pkg::MASK_W-1:0]     ram_mask,
	output logic                            pal
);

	logic                        cart_dl;
	logic                        take;
	logic [31:0]                 addr_ext;
	logic [31:0]                 hdr_ofs;
	logic                        hdr_fixed;
	logic [cart_pkg::SIZE_W-1:0] rom_size;
	logic [cart_pkg::SIZE_W-1:0] ram_size;
	logic                        rom_region;

	assign cart_dl  = bus.active && (bus.index[5:0] == cart_pkg::LOAD_IDX_CART);
	assign take     = cart_dl && bus.wr;
	assign addr_ext = 32'(bus.addr);

	// Where the size bytes sit for the forced layouts
	always_comb begin
		hdr_fixed = 1'b1;
		case (header_mode)
			cart_pkg::HDR_LOROM:   hdr_ofs = cart_pkg::HDR_OFS_LOROM;
			cart_pkg::HDR_HIROM:   hdr_ofs = cart_pkg::HDR_OFS_HIROM;
			cart_pkg::HDR_EXHIROM: hdr_ofs = cart_pkg::HDR_OFS_EXHIROM;
			default: begin
				hdr_ofs   = '0;
				hdr_fixed = 1'b0;
			end
		endcase
	end

	// ==============================
	// Header fields
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= cart_pkg::DEFAULT_ROM_SIZE;
			ram_size   <= '0;
			rom_region <= 1'b0;
			rom_type   <= '0;
			pal        <= 1'b0;
		end else if (cart_dl) begin
			if (take && bus.addr == '0) begin
				rom_size <= cart_pkg::DEFAULT_ROM_SIZE;
				ram_size <= '0;
				// Auto mode takes both sizes from the first byte
				if (header_mode == cart_pkg::HDR_AUTO && bus.data[7:0] != 8'h00) begin
					{ram_size, rom_size} <= bus.data[7:0];
				end
				case (header_mode)
					cart_pkg::HDR_NONE,
					cart_pkg::HDR_LOROM:   rom_type <= 8'd0;
					cart_pkg::HDR_HIROM:   rom_type <= 8'd1;
					cart_pkg::HDR_EXHIROM: rom_type <= 8'd2;
					default:               rom_type <= bus.data[15:8];
				endcase
			end
			if (take && addr_ext == 32'd2) begin
				rom_region <= bus.data[8];
			end
			if (take && hdr_fixed) begin
				if (addr_ext == hdr_ofs) begin
					rom_size <= bus.data[11:8];
				end
				// RAM size byte follows two bytes later
				if (addr_ext == hdr_ofs + 32'd2) begin
					ram_size <= bus.data[3:0];
				end
			end
		end else begin
			pal <= (region_sel == cart_pkg::REG_AUTO) ? rom_region :
				(region_sel == cart_pkg::REG_PAL);
		end
	end

	// Masks trail the size registers by one cycle
	always_ff @(posedge clk_sys) begin
		rom_mask <= cart_pkg::size_to_mask(rom_size);
		ram_mask <= (ram_size != '0) ? cart_pkg::size_to_mask(ram_size) : '0;
	end

	a_mode_range: assert property (@(posedge clk_sys) disable iff (RESET)
		header_mode <= cart_pkg::HDR_EXHIROM);

endmodule

//--- logic/load_bus_if.sv
`timescale 1ns/1ps

interface load_bus_if;

	// Word is valid when active and wr are both high
	logic                             active;
	logic [cart_pkg::LOAD_IDX_W-1:0]  index;
	logic [cart_pkg::LOAD_ADDR_W-1:0] addr;
	logic [cart_pkg::LOAD_DATA_W-1:0] data;
	logic                             wr;

	modport src (
		output active, index, addr, data, wr
	);

	modport sink (
		input active, index, addr, data, wr
	);

endinterface

//--- logic/mem_pkg.sv
package mem_pkg;

	localparam int CLEAR_ADDR_W = 17;

	localparam logic [CLEAR_ADDR_W-1:0] CLEAR_ADDR_STEP = 1;

	// Power-on patterns of the different console revisions
	typedef enum logic [1:0] {
		FILL_9966 = 2'd0,
		FILL_00FF = 2'd1,
		FILL_55   = 2'd2,
		FILL_FF   = 2'd3
	} fill_pattern_e;

	localparam logic [7:0] FILL_BYTE_00 = 8'h00;
	localparam logic [7:0] FILL_BYTE_55 = 8'h55;
	localparam logic [7:0] FILL_BYTE_66 = 8'h66;
	localparam logic [7:0] FILL_BYTE_99 = 8'h99;
	localparam logic [7:0] FILL_BYTE_FF = 8'hFF;

	function automatic logic [7:0] fill_byte(fill_pattern_e pat,
			logic [CLEAR_ADDR_W-1:0] addr);
		case (pat)
			FILL_9966: return (addr[8] ^ addr[2]) ? FILL_BYTE_66 : FILL_BYTE_99;
			FILL_00FF: return (addr[9] ^ addr[0]) ? FILL_BYTE_FF : FILL_BYTE_00;
			FILL_55:   return FILL_BYTE_55;
			default:   return FILL_BYTE_FF;
		endcase
	endfunction

endpackage

//--- logic/cart_pkg.sv
package cart_pkg;

	// ==============================
	// Download stream
	// ==============================

	localparam int LOAD_ADDR_W = 25;
	localparam int LOAD_DATA_W = 16;
	localparam int LOAD_IDX_W  = 8;

	// Cartridge image is index 0 in the low six bits
	localparam logic [5:0]            LOAD_IDX_CART = 6'd0;
	localparam logic [LOAD_IDX_W-1:0] LOAD_IDX_CODE = 8'hFF;

	// ==============================
	// Cartridge header
	// ==============================

	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_e;

	typedef enum logic [1:0] {
		REG_AUTO = 2'd0,
		REG_NTSC = 2'd1,
		REG_PAL  = 2'd2
	} region_sel_e;

	// Size byte offsets past a 512-byte copier header
	localparam logic [31:0] HDR_OFS_LOROM   = 32'h7FD6 + 32'h200;
	localparam logic [31:0] HDR_OFS_HIROM   = 32'hFFD6 + 32'h200;
	localparam logic [31:0] HDR_OFS_EXHIROM = 32'h40FFD6 + 32'h200;

	localparam int SIZE_W     = 4;
	localparam int MASK_W     = 24;
	localparam int ROM_TYPE_W = 8;

	localparam logic [SIZE_W-1:0] DEFAULT_ROM_SIZE = 4'd12;
	// Size code 0 means 1 KiB
	localparam logic [MASK_W-1:0] MASK_UNIT = 24'd1024;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	function automatic logic [MASK_W-1:0] size_to_mask(logic [SIZE_W-1:0] size);
		logic [MASK_W-1:0] span;
		span = MASK_UNIT << size;
		return span - MASK_W'(1);
	endfunction

endpackage
